// File: memSystem_testdata.txt
# op addr wdata byteMask expected  (F fetch, R load, W store, B fetch and load)
# hex fields, expected is unused for W
F 00000040 00000000 0 A5A50040
F 0000004C 00000000 0 A5A5004C
R 00000080 00000000 0 A5A50080
R 00000084 00000000 0 A5A50084
R 00000088 00000000 0 A5A50088
R 0000008C 00000000 0 A5A5008C
W 00000090 11223344 5 A5220044
R 00000090 00000000 0 A5220044
W 00000094 AABBCCDD C AABB0094
R 00000094 00000000 0 AABB0094
W 00000200 DEADBEEF F DEADBEEF
W 00000204 12345678 3 A5A55678
R 00000300 00000000 0 A5A50300
R 00000200 00000000 0 DEADBEEF
R 00000204 00000000 0 A5A55678
F 00000200 00000000 0 DEADBEEF
B 00000400 00000000 0 A5A50400
B 00000510 00000000 0 A5A50510

// File: filelist.f
cachePkg.sv
instrCache.sv
dataCache.sv
busArbiter.sv
ahbMemory.sv
memSystem.sv
memSystem_chk.sv
memSystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= memSystem_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(BUILD_DIR)

// File: memSystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memSystem_tb;

  localparam int BlockWords = 4;
  localparam int CacheLines = 16;
  localparam int MemWords   = 1024;
  localparam int MemLatency = 2;
  // slack for reset and the random gaps between operations
  localparam int MarginCycles = 200;

  logic               clk;
  logic               reset;
  cachePkg::addr_t    pc;
  cachePkg::word_t    instr;
  logic               iStall;
  cachePkg::dataReq_t dataReq;
  cachePkg::word_t    readData;
  logic               dStall;

  // one entry per operation line of the test data
  byte             opQ[$];
  cachePkg::addr_t addrQ[$];
  cachePkg::word_t wdataQ[$];
  cachePkg::mask_t maskQ[$];
  cachePkg::word_t expQ[$];
  logic            loaded;
  logic [31:0]     rngState;

  memSystem #(
    .BlockWords(BlockWords),
    .CacheLines(CacheLines),
    .MemWords(MemWords),
    .MemLatency(MemLatency)
  ) UUT (
    .clk(clk), .reset(reset), .pc(pc), .instr(instr), .iStall(iStall),
    .dataReq(dataReq), .readData(readData), .dStall(dStall));

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abortRun(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic checkInstr(string name, cachePkg::word_t expected, cachePkg::word_t actual);
    if (actual !== expected) begin
      abortRun($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic checkData(string name, cachePkg::word_t expected, cachePkg::word_t actual);
    if (actual !== expected) begin
      abortRun($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // lines starting with # are skipped up to the newline
  task automatic loadTests();
    int              fd;
    int              code;
    int              ch;
    byte             op;
    cachePkg::addr_t a;
    cachePkg::word_t w;
    cachePkg::mask_t m;
    cachePkg::word_t e;
    fd = $fopen("memSystem_testdata.txt", "r");
    if (fd == 0) begin
      abortRun("could not open memSystem_testdata.txt for reading");
    end
    while ($fscanf(fd, " %c", op) == 1) begin
      if (op == "#") begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        code = $fscanf(fd, "%h %h %h %h", a, w, m, e);
        if (code != 4) begin
          abortRun($sformatf("test data line after operation %0d is malformed", opQ.size()));
        end
        opQ.push_back(op);
        addrQ.push_back(a);
        wdataQ.push_back(w);
        maskQ.push_back(m);
        expQ.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // drive one operation and hold it until each stall it depends on is low
  task automatic runOp(int idx);
    string              name;
    byte                op;
    logic               gotI;
    logic               gotD;
    cachePkg::dataReq_t req;
    op   = opQ[idx];
    name = $sformatf("op%0d %c %h", idx, op, addrQ[idx]);
    req  = '0;
    gotI = !(op == "F" || op == "B");
    gotD = (op == "F");
    if (!gotD) begin
      req.read     = (op != "W");
      req.write    = (op == "W");
      req.addr     = addrQ[idx];
      req.wdata    = wdataQ[idx];
      req.byteMask = maskQ[idx];
    end
    @(posedge clk);
    if (!gotI) begin
      pc <= addrQ[idx];
    end
    dataReq <= req;
    // stalls settle by mid-cycle, so look at the falling edge
    while (!(gotI && gotD)) begin
      @(negedge clk);
      if (!gotI && !iStall) begin
        checkInstr(name, expQ[idx], instr);
        gotI = 1'b1;
      end
      if (!gotD && !dStall) begin
        // store result is checked by a later load
        if (op != "W") begin
          checkData(name, expQ[idx], readData);
        end
        gotD = 1'b1;
      end
    end
    // the access completes on this edge
    @(posedge clk);
    dataReq <= '0;
  endtask

  initial begin
    reset    = 1'b1;
    pc       = '0;
    dataReq  = '0;
    loaded   = 1'b0;
    rngState = 32'h6735;
    loadTests();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < opQ.size(); i++) begin
      runOp(i);
      rngState = xorshift(rngState);
      repeat (rngState[1:0]) @(posedge clk);
    end
    // assertions of the last edge have reported by the falling edge
    @(negedge clk);
    if (UUT.chk.errCount != 0) begin
      abortRun($sformatf("%0d bus protocol assertions failed", UUT.chk.errCount));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

  // a failed bus assertion ends the run right away
  always @(negedge clk) begin
    if (UUT.chk.errCount != 0) begin
      abortRun($sformatf("%0d bus protocol assertions failed", UUT.chk.errCount));
    end
  end

  // every line may cost up to 4 block transfers
  initial begin
    wait (loaded === 1'b1);
    repeat (opQ.size() * 4 * BlockWords * (MemLatency + 2) + MarginCycles) @(posedge clk);
    abortRun("timeout: the operations did not finish in the expected number of cycles");
  end

endmodule

`default_nettype wire

// File: memSystem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module memSystem_chk #(
  parameter int MemLatency = 2
) (
  input wire logic              clk,
  input wire logic              reset,
  input wire logic              iStall,
  input wire logic              dStall,
  input wire cachePkg::busReq_t instrBus,
  input wire cachePkg::busReq_t dataBus,
  input wire cachePkg::busReq_t memBus,
  input wire cachePkg::busRsp_t memRsp
);

  // failed assertions so far
  int errCount = 0;

  // a pending beat keeps address and direction until ready
  assert property (@(posedge clk) disable iff (reset)
    memBus.request && !memRsp.ready |=>
      memBus.request && $stable(memBus.addr) && $stable(memBus.write))
  else begin
    errCount++;
    $error("memBus beat changed before ready");
  end

  // ready only answers a beat that has waited out its wait states
  assert property (@(posedge clk) disable iff (reset)
    memRsp.ready |->
      memBus.request && $past(memBus.request && !memRsp.ready, MemLatency))
  else begin
    errCount++;
    $error("memRsp ready without a memBus request pending for the wait states");
  end

  // first cycle out of reset is quiet
  assert property (@(posedge clk) $past(reset) && !reset |->
    !iStall && !dStall && !instrBus.request && !dataBus.request)
  else begin
    errCount++;
    $error("stall or bus request high right after reset");
  end

endmodule

bind memSystem memSystem_chk #(.MemLatency(MemLatency)) chk (
  .clk(clk), .reset(reset), .iStall(iStall), .dStall(dStall),
  .instrBus(instrBus), .dataBus(dataBus), .memBus(memBus), .memRsp(memRsp));

`default_nettype wire

// File: memSystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSystem #(
  parameter int BlockWords = 4,
  parameter int CacheLines = 16,
  parameter int MemWords   = 1024,
  parameter int MemLatency = 2
) (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire cachePkg::addr_t    pc,
  output cachePkg::word_t         instr,
  output logic                    iStall,
  input  wire cachePkg::dataReq_t dataReq,
  output cachePkg::word_t         readData,
  output logic                    dStall
);

  // each cache's own bus port
  cachePkg::busReq_t instrBus;
  cachePkg::busReq_t dataBus;
  cachePkg::busRsp_t instrRsp;
  cachePkg::busRsp_t dataRsp;
  // shared bus after the arbiter
  cachePkg::busReq_t memBus;
  cachePkg::busRsp_t memRsp;

  instrCache #(.BlockWords(BlockWords), .CacheLines(CacheLines)) iCache (
    .clk(clk), .reset(reset), .pc(pc), .instr(instr), .iStall(iStall),
    .busReq(instrBus), .busRsp(instrRsp));

  dataCache #(.BlockWords(BlockWords), .CacheLines(CacheLines)) dCache (
    .clk(clk), .reset(reset), .dataReq(dataReq), .readData(readData), .dStall(dStall),
    .busReq(dataBus), .busRsp(dataRsp));

  busArbiter busArb (
    .clk(clk), .reset(reset), .dataBus(dataBus), .instrBus(instrBus),
    .dataRsp(dataRsp), .instrRsp(instrRsp), .memBus(memBus), .memRsp(memRsp));

  // single-word beats with fixed wait states
  ahbMemory #(.MemWords(MemWords), .MemLatency(MemLatency)) ahb (
    .clk(clk), .reset(reset), .memBus(memBus), .memRsp(memRsp));

endmodule

`default_nettype wire

// File: ahbMemory.sv
`timescale 1ns/1ps
`default_nettype none

module ahbMemory #(
  parameter int MemWords   = 1024,
  parameter int MemLatency = 2
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire cachePkg::busReq_t memBus,
  output cachePkg::busRsp_t      memRsp
);

  localparam int AddrBits = $clog2(MemWords);
  // counter must hold MemLatency itself
  localparam int CntBits  = (MemLatency > 0) ? $clog2(MemLatency + 1) : 1;

  cachePkg::word_t     memArr [MemWords];
  logic [AddrBits-1:0] wordIdx;
  logic [CntBits-1:0]  waitCnt;
  logic                beatDone;

  // word addressed, upper address bits wrap
  assign wordIdx  = memBus.addr[2 +: AddrBits];
  // first pending cycle sees waitCnt at 0
  assign beatDone = memBus.request && (waitCnt == CntBits'(MemLatency));

  always_comb begin
    memRsp.ready = beatDone;
    memRsp.rdata = memArr[wordIdx];
  end

  // wait states of the current beat
  always_ff @(posedge clk) begin
    if (reset) begin
      waitCnt <= '0;
    end else if (beatDone) begin
      waitCnt <= '0;
    end else if (memBus.request) begin
      waitCnt <= waitCnt + 1'b1;
    end
  end

  // known pattern at reset, writes land in the ready cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < MemWords; i++) begin
        memArr[i] <= cachePkg::memInit(cachePkg::addr_t'(i) << 2);
      end
    end else if (beatDone && memBus.write) begin
      memArr[wordIdx] <= memBus.wdata;
    end
  end

endmodule

`default_nettype wire

// File: busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire cachePkg::busReq_t dataBus,
  input  wire cachePkg::busReq_t instrBus,
  output cachePkg::busRsp_t      dataRsp,
  output cachePkg::busRsp_t      instrRsp,
  output cachePkg::busReq_t      memBus,
  input  wire cachePkg::busRsp_t memRsp
);

  cachePkg::grant_t grant;
  cachePkg::grant_t grantNext;

  // data side wins when both ask at once
  // a grant is held until its owner lets request fall after the block
  always_comb begin
    grantNext = grant;
    unique case (grant)
      cachePkg::GrantNone: begin
        if (dataBus.request) begin
          grantNext = cachePkg::GrantData;
        end else if (instrBus.request) begin
          grantNext = cachePkg::GrantInstr;
        end
      end
      cachePkg::GrantData: begin
        if (!dataBus.request) begin
          grantNext = cachePkg::GrantNone;
        end
      end
      cachePkg::GrantInstr: begin
        if (!instrBus.request) begin
          grantNext = cachePkg::GrantNone;
        end
      end
      default: grantNext = cachePkg::GrantNone;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      grant <= cachePkg::GrantNone;
    end else begin
      grant <= grantNext;
    end
  end

  // forward the owner's beat, the other cache only sees ready low
  always_comb begin
    memBus         = '0;
    dataRsp.ready  = 1'b0;
    instrRsp.ready = 1'b0;
    dataRsp.rdata  = memRsp.rdata;
    instrRsp.rdata = memRsp.rdata;
    if (grant == cachePkg::GrantData) begin
      memBus        = dataBus;
      dataRsp.ready = memRsp.ready;
    end else if (grant == cachePkg::GrantInstr) begin
      memBus         = instrBus;
      instrRsp.ready = memRsp.ready;
    end
  end

endmodule

`default_nettype wire

// File: dataCache.sv
`timescale 1ns/1ps
`default_nettype none

module dataCache #(
  parameter int BlockWords = 4,
  parameter int CacheLines = 16
) (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire cachePkg::dataReq_t dataReq,
  output cachePkg::word_t         readData,
  output logic                    dStall,
  output cachePkg::busReq_t       busReq,
  input  wire cachePkg::busRsp_t  busRsp
);

  // address split: tag | line | word | byte
  localparam int OffBits = $clog2(BlockWords);
  localparam int IdxBits = $clog2(CacheLines);
  localparam int TagBits = 30 - OffBits - IdxBits;

  cachePkg::cacheState_t state;
  logic [TagBits-1:0]    tagArr [CacheLines];
  logic [CacheLines-1:0] validArr;
  logic [CacheLines-1:0] dirtyArr;
  cachePkg::word_t       dataArr [CacheLines*BlockWords];
  logic [OffBits-1:0]    reqWord;
  logic [IdxBits-1:0]    reqLine;
  logic [TagBits-1:0]    reqTag;
  logic [OffBits-1:0]    wordCnt;
  logic [IdxBits-1:0]    missLine;
  logic [TagBits-1:0]    missTag;
  cachePkg::word_t       mergedWord;
  logic                  access;
  logic                  hit;
  logic                  miss;
  logic                  storeHit;
  logic                  lastBeat;

  assign reqWord = dataReq.addr[2 +: OffBits];
  assign reqLine = dataReq.addr[2 + OffBits +: IdxBits];
  assign reqTag  = dataReq.addr[31 -: TagBits];

  assign access   = dataReq.read || dataReq.write;
  assign hit      = validArr[reqLine] && (tagArr[reqLine] == reqTag);
  assign miss     = (state == cachePkg::Idle) && access && !hit;
  assign storeHit = (state == cachePkg::Idle) && dataReq.write && hit;
  assign lastBeat = busRsp.ready && (wordCnt == OffBits'(BlockWords - 1));

  assign readData = dataArr[{reqLine, reqWord}];
  // stall through the whole write-back and refill
  assign dStall   = access && ((state != cachePkg::Idle) || !hit);

  // byte-masked merge of store data into the current word
  always_comb begin
    mergedWord = dataArr[{reqLine, reqWord}];
    for (int b = 0; b < 4; b++) begin
      if (dataReq.byteMask[b]) begin
        mergedWord[8*b +: 8] = dataReq.wdata[8*b +: 8];
      end
    end
  end

  // request stays up from write-back straight into refill
  // victim address comes from the old tag still in the array
  always_comb begin
    busReq.request = (state != cachePkg::Idle);
    busReq.write   = (state == cachePkg::WriteBack);
    busReq.wdata   = dataArr[{missLine, wordCnt}];
    if (state == cachePkg::WriteBack) begin
      busReq.addr = {tagArr[missLine], missLine, wordCnt, 2'b00};
    end else begin
      busReq.addr = {missTag, missLine, wordCnt, 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= cachePkg::Idle;
      validArr <= '0;
      dirtyArr <= '0;
      wordCnt  <= '0;
    end else begin
      unique case (state)
        cachePkg::Idle: begin
          if (miss && validArr[reqLine] && dirtyArr[reqLine]) begin
            state <= cachePkg::WriteBack;
          end else if (miss) begin
            state <= cachePkg::Refill;
          end else if (storeHit) begin
            dirtyArr[reqLine] <= 1'b1;
          end
        end
        cachePkg::WriteBack: begin
          if (busRsp.ready) begin
            wordCnt <= wordCnt + 1'b1;
          end
          if (lastBeat) begin
            state <= cachePkg::Refill;
          end
        end
        cachePkg::Refill: begin
          if (busRsp.ready) begin
            wordCnt <= wordCnt + 1'b1;
          end
          // a store miss merges on the next cycle as a hit
          if (lastBeat) begin
            validArr[missLine] <= 1'b1;
            dirtyArr[missLine] <= 1'b0;
            state              <= cachePkg::Idle;
          end
        end
        default: state <= cachePkg::Idle;
      endcase
    end
  end

  // miss address latch, refill data, tag update and store merge
  always_ff @(posedge clk) begin
    if (miss) begin
      missLine <= reqLine;
      missTag  <= reqTag;
    end
    if (state == cachePkg::Refill && busRsp.ready) begin
      dataArr[{missLine, wordCnt}] <= busRsp.rdata;
    end
    if (state == cachePkg::Refill && lastBeat) begin
      tagArr[missLine] <= missTag;
    end
    if (storeHit) begin
      dataArr[{reqLine, reqWord}] <= mergedWord;
    end
  end

endmodule

`default_nettype wire

// File: instrCache.sv
`timescale 1ns/1ps
`default_nettype none

module instrCache #(
  parameter int BlockWords = 4,
  parameter int CacheLines = 16
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire cachePkg::addr_t   pc,
  output cachePkg::word_t        instr,
  output logic                   iStall,
  output cachePkg::busReq_t      busReq,
  input  wire cachePkg::busRsp_t busRsp
);

  // address split: tag | line | word | byte
  localparam int OffBits = $clog2(BlockWords);
  localparam int IdxBits = $clog2(CacheLines);
  localparam int TagBits = 30 - OffBits - IdxBits;

  cachePkg::cacheState_t state;
  logic [TagBits-1:0]    tagArr [CacheLines];
  logic [CacheLines-1:0] validArr;
  cachePkg::word_t       dataArr [CacheLines*BlockWords];
  logic [OffBits-1:0]    pcWord;
  logic [IdxBits-1:0]    pcLine;
  logic [TagBits-1:0]    pcTag;
  logic [OffBits-1:0]    wordCnt;
  logic [IdxBits-1:0]    missLine;
  logic [TagBits-1:0]    missTag;
  logic                  fetchEn;
  logic                  hit;
  logic                  lastBeat;

  assign pcWord = pc[2 +: OffBits];
  assign pcLine = pc[2 + OffBits +: IdxBits];
  assign pcTag  = pc[31 -: TagBits];

  assign hit   = validArr[pcLine] && (tagArr[pcLine] == pcTag);
  assign instr = dataArr[{pcLine, pcWord}];
  // fetching starts one cycle after reset drops
  // any refill in flight also stalls, so a half-written line is never read
  assign iStall   = fetchEn && ((state != cachePkg::Idle) || !hit);
  assign lastBeat = busRsp.ready && (wordCnt == OffBits'(BlockWords - 1));

  // read-only, so the bus only ever sees reads of the missed block
  always_comb begin
    busReq.request = (state == cachePkg::Refill);
    busReq.write   = 1'b0;
    busReq.addr    = {missTag, missLine, wordCnt, 2'b00};
    busReq.wdata   = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= cachePkg::Idle;
      validArr <= '0;
      wordCnt  <= '0;
      fetchEn  <= 1'b0;
    end else begin
      fetchEn <= 1'b1;
      unique case (state)
        cachePkg::Idle: begin
          if (fetchEn && !hit) begin
            state <= cachePkg::Refill;
          end
        end
        cachePkg::Refill: begin
          // word counter wraps back to 0 after the last beat
          if (busRsp.ready) begin
            wordCnt <= wordCnt + 1'b1;
          end
          if (lastBeat) begin
            validArr[missLine] <= 1'b1;
            state              <= cachePkg::Idle;
          end
        end
        default: state <= cachePkg::Idle;
      endcase
    end
  end

  // miss address latch and line arrays
  always_ff @(posedge clk) begin
    if (state == cachePkg::Idle && fetchEn && !hit) begin
      missLine <= pcLine;
      missTag  <= pcTag;
    end
    if (state == cachePkg::Refill && busRsp.ready) begin
      dataArr[{missLine, wordCnt}] <= busRsp.rdata;
    end
    if (state == cachePkg::Refill && lastBeat) begin
      tagArr[missLine] <= missTag;
    end
  end

endmodule

`default_nettype wire

// File: cachePkg.sv
`default_nettype none

package cachePkg;

  // byte address as seen by the processor and the bus
  typedef logic [31:0] addr_t;

  // one memory word
  typedef logic [31:0] word_t;

  // byte enables, bit i enables byte i of the word
  typedef logic [3:0] mask_t;

  // one bus beat request from a cache or the arbiter
  typedef struct packed {
    logic  request;
    logic  write;
    addr_t addr;
    word_t wdata;
  } busReq_t;

  // memory response, ready is high for one cycle per beat
  typedef struct packed {
    logic  ready;
    word_t rdata;
  } busRsp_t;

  // processor data port
  typedef struct packed {
    logic  read;
    logic  write;
    addr_t addr;
    word_t wdata;
    mask_t byteMask;
  } dataReq_t;

  // cache controller states, instr cache skips WriteBack
  typedef enum logic [1:0] {Idle, WriteBack, Refill} cacheState_t;

  // bus owner
  typedef enum logic [1:0] {GrantNone, GrantData, GrantInstr} grant_t;

  // power-up contents of memory at a byte address
  function automatic word_t memInit(addr_t addr);
    return addr ^ 32'hA5A50000;
  endfunction

endpackage

`default_nettype wire
